//--- src/spi_rd_macros.svh
`ifndef SPI_RD_MACROS_SVH
`define SPI_RD_MACROS_SVH

////////////////////////////////////////
// SPI timing
////////////////////////////////////////

// System clocks per half SPI clock, 4 cycles per bit
`define SPI_CLKS_PER_HALF_BIT 2

`define SPI_CS_INACTIVE_CLKS 2  // Min chip-select high time between frames

////////////////////////////////////////
// Frame layout and flow control
////////////////////////////////////////

`define SPI_FRAME_BYTES 3       // Command, address, dummy
`define SPI_TX_CREDITS  2       // Request buffer depth in execute

// Sensor read command and filler byte
`define SNS_CMD_READ   8'h0B
`define SNS_DUMMY_BYTE 8'h00

`endif

//--- src/spi_bus_pkg.sv
package spi_bus_pkg;

  ////////////////////////////////////////
  // Byte stream between the stages
  ////////////////////////////////////////

  // Request from decode into the execute buffer
  typedef struct packed {
    logic       valid;  // One-cycle strobe, spends one credit
    logic [7:0] data;   // Byte for MOSI, MSB first
    logic       last;   // Chip-select goes high after this byte
  } spi_req_t;

  // Received byte from execute to result
  // No back-pressure on this path
  typedef struct packed {
    logic       valid;  // Pulses when eighth bit sampled
    logic [7:0] data;   // Byte shifted in from MISO
    logic       last;   // Copied from the request that shifted it
  } spi_rsp_t;

endpackage

//--- src/sensor_pkg.sv
package sensor_pkg;

  ////////////////////////////////////////
  // Sensor side types
  ////////////////////////////////////////

  // Register address sent as second frame byte
  typedef logic [7:0] reg_addr_t;

  typedef logic [3:0] nibble_t;  // One hex digit

  // Seven-segment pattern, active low
  // Bit 0 is segment a, bit 6 is segment g
  typedef logic [6:0] seg7_t;

endpackage

//--- src/reg_read_decode.sv
`timescale 1ns/10ps
`include "spi_rd_macros.svh"

module reg_read_decode
(
  input  logic                  i_Clk,
  input  logic                  i_Rst_L,
  input  logic                  i_start,     // One-cycle read request
  input  sensor_pkg::reg_addr_t i_reg_addr,
  input  logic                  i_credit,    // Execute freed a buffer slot
  input  logic                  i_rd_done,   // Result byte captured
  output spi_bus_pkg::spi_req_t o_req,
  output logic                  o_busy
);
  import sensor_pkg::*;

  localparam int CRED_W = $clog2(`SPI_TX_CREDITS + 1);
  localparam int IDX_W  = $clog2(`SPI_FRAME_BYTES);

  typedef enum logic [1:0]
  {
    ST_IDLE,
    ST_ISSUE,   // Sending frame bytes as credits allow
    ST_WAIT     // All bytes sent, waiting for result
  } dec_state_t;

  dec_state_t        state;
  logic [CRED_W-1:0] credit_cnt;
  logic [IDX_W-1:0]  byte_idx;   // Position in frame
  reg_addr_t         r_addr;     // Address held for the frame
  logic              issue;
  logic              last_byte;

  ////////////////////////////////////////
  // Request generation
  ////////////////////////////////////////

  // Only send while execute has room
  assign issue     = (state == ST_ISSUE) && (credit_cnt != '0);
  assign last_byte = (byte_idx == IDX_W'(`SPI_FRAME_BYTES - 1));

  always_comb
  begin
    o_req.valid = issue;
    o_req.last  = last_byte;  // Closes the frame
    case (byte_idx)
      IDX_W'(0): o_req.data = `SNS_CMD_READ;
      IDX_W'(1): o_req.data = r_addr;
      default:   o_req.data = `SNS_DUMMY_BYTE;  // Clocks the read byte in
    endcase
  end

  assign o_busy = (state != ST_IDLE);

  ////////////////////////////////////////
  // Frame sequencer
  ////////////////////////////////////////

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (~i_Rst_L)
    begin
      state    <= ST_IDLE;
      byte_idx <= '0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          if (i_start)  // Starts while busy never get here
          begin
            byte_idx <= '0;
            state    <= ST_ISSUE;
          end
        end
        ST_ISSUE:
        begin
          if (issue)
          begin
            byte_idx <= byte_idx + 1'b1;
            if (last_byte)
            begin
              state <= ST_WAIT;
            end
          end
        end
        ST_WAIT:
        begin
          if (i_rd_done)
          begin
            state <= ST_IDLE;  // Busy drops next cycle
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Latch address on an accepted start
  always_ff @(posedge i_Clk)
  begin
    if (i_start && (state == ST_IDLE))
    begin
      r_addr <= i_reg_addr;
    end
  end

  // Credit count, spend on issue, refill on execute pop
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (~i_Rst_L)
    begin
      credit_cnt <= CRED_W'(`SPI_TX_CREDITS);
    end
    else
    begin
      credit_cnt <= credit_cnt + CRED_W'(i_credit) - CRED_W'(issue);
    end
  end

endmodule

//--- src/spi_byte_execute.sv
`timescale 1ns/10ps
`include "spi_rd_macros.svh"

module spi_byte_execute
(
  input  logic                  i_Clk,
  input  logic                  i_Rst_L,
  input  spi_bus_pkg::spi_req_t i_req,
  input  logic                  i_spi_miso,
  output logic                  o_credit,   // Slot freed, one cycle
  output spi_bus_pkg::spi_rsp_t o_rsp,
  output logic                  o_spi_clk,
  output logic                  o_spi_mosi,
  output logic                  o_spi_cs_n
);
  import spi_bus_pkg::*;

  localparam int DEPTH = `SPI_TX_CREDITS;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int HALF  = `SPI_CLKS_PER_HALF_BIT;
  localparam int DIV_W = $clog2(HALF * 2);
  localparam int GAP_W = $clog2(`SPI_CS_INACTIVE_CLKS + 1);

  typedef enum logic [1:0]
  {
    CS_IDLE,
    CS_XFER,   // Chip-select low, bytes shifting
    CS_GAP     // Chip-select high hold time
  } cs_state_t;

  spi_req_t         fifo_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fifo_cnt;
  spi_req_t         head;       // Next entry for the shifter
  logic             pop;
  logic             push_fifo;
  logic             pop_fifo;

  cs_state_t        cs_state;
  logic             cs_n;
  logic [GAP_W-1:0] gap_cnt;

  logic [DIV_W-1:0] div_cnt;    // Position inside one SPI bit
  logic [4:0]       edge_cnt;   // SPI clock edges left in byte
  logic             spi_clk;
  logic             rise;
  logic             fall;
  logic             shift_idle;
  logic [7:0]       tx_shift;
  logic [6:0]       rx_shift;
  logic             cur_last;

  logic             rsp_valid;
  logic [7:0]       rsp_data;
  logic             rsp_last;

  ////////////////////////////////////////
  // Request buffer
  ////////////////////////////////////////

  // Empty buffer passes the input straight through
  assign head = (fifo_cnt == '0) ? i_req : fifo_mem[rd_ptr];

  assign pop = head.valid &&
               ((cs_state == CS_IDLE) ||
                ((cs_state == CS_XFER) && shift_idle && !cur_last));

  assign push_fifo = i_req.valid && !(pop && (fifo_cnt == '0));  // Bypassed entries skip
  assign pop_fifo  = pop && (fifo_cnt != '0);
  assign o_credit  = pop;

  always_ff @(posedge i_Clk)
  begin
    if (push_fifo)
    begin
      fifo_mem[wr_ptr] <= i_req;
    end
  end

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (~i_Rst_L)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fifo_cnt <= '0;
    end
    else
    begin
      if (push_fifo)
      begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_fifo)
      begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      fifo_cnt <= fifo_cnt + CNT_W'(push_fifo) - CNT_W'(pop_fifo);  // Credits bound this
    end
  end

  ////////////////////////////////////////
  // Chip-select control
  ////////////////////////////////////////

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (~i_Rst_L)
    begin
      cs_state <= CS_IDLE;
      cs_n     <= 1'b1;
      gap_cnt  <= '0;
    end
    else
    begin
      case (cs_state)
        CS_IDLE:
        begin
          if (pop)
          begin
            cs_n     <= 1'b0;  // Low on the cycle after accept
            cs_state <= CS_XFER;
          end
        end
        CS_XFER:
        begin
          // Byte finished and it closed the frame
          if (shift_idle && cur_last)
          begin
            cs_n     <= 1'b1;
            gap_cnt  <= GAP_W'(`SPI_CS_INACTIVE_CLKS - 1);
            cs_state <= CS_GAP;
          end
        end
        CS_GAP:
        begin
          if (gap_cnt != '0)
          begin
            gap_cnt <= gap_cnt - 1'b1;
          end
          else
          begin
            cs_state <= CS_IDLE;  // Buffered entries may go now
          end
        end
        default:
        begin
          cs_n     <= 1'b1;
          cs_state <= CS_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Shift engine, mode 0
  ////////////////////////////////////////

  assign shift_idle = (edge_cnt == '0);
  assign rise = !shift_idle && (div_cnt == DIV_W'(HALF - 1));
  assign fall = !shift_idle && (div_cnt == DIV_W'(2 * HALF - 1));

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (~i_Rst_L)
    begin
      edge_cnt <= '0;
      div_cnt  <= '0;
      spi_clk  <= 1'b0;  // Idles low
      tx_shift <= '0;
      cur_last <= 1'b0;
    end
    else
    begin
      if (pop)
      begin
        edge_cnt <= 5'd16;     // 8 rising, 8 falling
        div_cnt  <= '0;
        tx_shift <= head.data;  // MSB on MOSI right away
        cur_last <= head.last;
      end
      else if (!shift_idle)
      begin
        if (fall)
        begin
          edge_cnt <= edge_cnt - 1'b1;
          div_cnt  <= '0;
          spi_clk  <= 1'b0;
          tx_shift <= {tx_shift[6:0], 1'b0};  // Next bit on falling edge
        end
        else if (rise)
        begin
          edge_cnt <= edge_cnt - 1'b1;
          div_cnt  <= div_cnt + 1'b1;
          spi_clk  <= 1'b1;
        end
        else
        begin
          div_cnt <= div_cnt + 1'b1;
        end
      end
    end
  end

  // Sample MISO together with the rising edge
  always_ff @(posedge i_Clk)
  begin
    if (rise)
    begin
      rx_shift <= {rx_shift[5:0], i_spi_miso};
    end
  end

  // Eighth rising edge is the one with two edges left
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (~i_Rst_L)
    begin
      rsp_valid <= 1'b0;
    end
    else
    begin
      rsp_valid <= rise && (edge_cnt == 5'd2);
    end
  end

  always_ff @(posedge i_Clk)
  begin
    if (rise && (edge_cnt == 5'd2))
    begin
      rsp_data <= {rx_shift, i_spi_miso};
      rsp_last <= cur_last;
    end
  end

  assign o_rsp      = spi_rsp_t'{valid: rsp_valid, data: rsp_data, last: rsp_last};
  assign o_spi_clk  = spi_clk;
  assign o_spi_mosi = tx_shift[7];
  assign o_spi_cs_n = cs_n;

endmodule

//--- src/hex_result.sv
`timescale 1ns/10ps

module hex_result
(
  input  logic                  i_Clk,
  input  logic                  i_Rst_L,
  input  spi_bus_pkg::spi_rsp_t i_rsp,
  output logic                  o_rd_valid,  // One cycle per frame
  output logic [7:0]            o_rd_data,
  output sensor_pkg::seg7_t     o_hex_lo,
  output sensor_pkg::seg7_t     o_hex_hi
);
  import sensor_pkg::*;

  nibble_t nib_lo;
  nibble_t nib_hi;
  logic    take;

  // Hex digit to active-low segments, g is bit 6
  function automatic seg7_t hex_to_seg7(input nibble_t nib);
    case (nib)
      4'h0:    hex_to_seg7 = 7'b1000000;
      4'h1:    hex_to_seg7 = 7'b1111001;
      4'h2:    hex_to_seg7 = 7'b0100100;
      4'h3:    hex_to_seg7 = 7'b0110000;
      4'h4:    hex_to_seg7 = 7'b0011001;
      4'h5:    hex_to_seg7 = 7'b0010010;
      4'h6:    hex_to_seg7 = 7'b0000010;
      4'h7:    hex_to_seg7 = 7'b1111000;
      4'h8:    hex_to_seg7 = 7'b0000000;
      4'h9:    hex_to_seg7 = 7'b0010000;
      4'hA:    hex_to_seg7 = 7'b0001000;
      4'hB:    hex_to_seg7 = 7'b0000011;  // Lower case b
      4'hC:    hex_to_seg7 = 7'b1000110;
      4'hD:    hex_to_seg7 = 7'b0100001;  // Lower case d
      4'hE:    hex_to_seg7 = 7'b0000110;
      default: hex_to_seg7 = 7'b0001110;
    endcase
  endfunction

  // Only the byte clocked during the dummy counts
  assign take = i_rsp.valid & i_rsp.last;

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (~i_Rst_L)
    begin
      o_rd_valid <= 1'b0;
      o_rd_data  <= 8'h00;  // Displays show 00 out of reset
    end
    else
    begin
      o_rd_valid <= take;
      if (take)
      begin
        o_rd_data <= i_rsp.data;
      end
    end
  end

  // Digits follow the held byte in the same cycle
  assign nib_lo   = o_rd_data[3:0];
  assign nib_hi   = o_rd_data[7:4];
  assign o_hex_lo = hex_to_seg7(nib_lo);
  assign o_hex_hi = hex_to_seg7(nib_hi);

endmodule

//--- src/spi_reg_reader_top.sv
`timescale 1ns/10ps

module spi_reg_reader_top
(
  input  logic                  i_Clk,
  input  logic                  i_Rst_L,
  input  logic                  i_start,
  input  sensor_pkg::reg_addr_t i_reg_addr,
  input  logic                  i_spi_miso,
  output logic                  o_spi_clk,
  output logic                  o_spi_mosi,
  output logic                  o_spi_cs_n,
  output logic                  o_busy,
  output logic                  o_rd_valid,
  output logic [7:0]            o_rd_data,
  output sensor_pkg::seg7_t     o_hex_lo,
  output sensor_pkg::seg7_t     o_hex_hi
);
  import spi_bus_pkg::*;

  spi_req_t req;     // Decode to execute
  spi_rsp_t rsp;     // Execute to result
  logic     credit;  // Execute back to decode

  ////////////////////////////////////////
  // Decode, execute, result
  ////////////////////////////////////////

  reg_read_decode u_decode
  (
    .i_Clk      (i_Clk),
    .i_Rst_L    (i_Rst_L),
    .i_start    (i_start),
    .i_reg_addr (i_reg_addr),
    .i_credit   (credit),
    .i_rd_done  (o_rd_valid),  // Result capture ends busy
    .o_req      (req),
    .o_busy     (o_busy)
  );

  spi_byte_execute u_execute
  (
    .i_Clk      (i_Clk),
    .i_Rst_L    (i_Rst_L),
    .i_req      (req),
    .i_spi_miso (i_spi_miso),
    .o_credit   (credit),
    .o_rsp      (rsp),
    .o_spi_clk  (o_spi_clk),
    .o_spi_mosi (o_spi_mosi),
    .o_spi_cs_n (o_spi_cs_n)
  );

  hex_result u_result
  (
    .i_Clk      (i_Clk),
    .i_Rst_L    (i_Rst_L),
    .i_rsp      (rsp),
    .o_rd_valid (o_rd_valid),
    .o_rd_data  (o_rd_data),
    .o_hex_lo   (o_hex_lo),
    .o_hex_hi   (o_hex_hi)
  );

endmodule

//--- verification/spi_reg_reader_checker.sv
`timescale 1ns/10ps

module spi_reg_reader_checker
(
  input logic i_Clk,
  input logic i_Rst_L,
  input logic i_spi_clk,
  input logic i_spi_cs_n,
  input logic i_rd_valid,
  input logic i_busy
);
  int fail_cnt = 0;  // Failed assertion count

  // Mode 0, clock idles low outside a frame
  a_clk_idle: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
                               i_spi_cs_n |-> !i_spi_clk)
    else
    begin
      fail_cnt++;
      $error("SPI clock high while chip-select is high");
    end

  a_valid_pulse: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
                                  i_rd_valid |=> !i_rd_valid)  // One cycle per frame
    else
    begin
      fail_cnt++;
      $error("o_rd_valid high for two cycles in a row");
    end

  a_busy_reset: assert property (@(posedge i_Clk) !i_Rst_L |-> !i_busy)
    else
    begin
      fail_cnt++;
      $error("o_busy high during reset");
    end

endmodule

bind spi_reg_reader_top spi_reg_reader_checker u_checker
(
  .i_Clk      (i_Clk),
  .i_Rst_L    (i_Rst_L),
  .i_spi_clk  (o_spi_clk),
  .i_spi_cs_n (o_spi_cs_n),
  .i_rd_valid (o_rd_valid),
  .i_busy     (o_busy)
);

//--- verification/tb_spi_reg_reader.sv
`timescale 1ns/10ps
`include "spi_rd_macros.svh"

module tb_spi_reg_reader;
  import sensor_pkg::*;

  localparam int         CLK_PERIOD      = 20;
  localparam int         NUM_READS       = 40;
  localparam int         READ_TIMEOUT    = 400;                       // Cycles per read
  localparam int         WATCHDOG_CYCLES = NUM_READS * 200 + 1000;
  localparam time        CS_GAP_MIN      = 64'(`SPI_CS_INACTIVE_CLKS * CLK_PERIOD);
  localparam logic [7:0] FILLER          = 8'hC3;  // Slave output outside the data byte

  logic       i_Clk = 1'b0;
  logic       i_Rst_L;
  logic       i_start;
  reg_addr_t  i_reg_addr;
  logic       i_spi_miso = 1'b0;
  logic       o_spi_clk;
  logic       o_spi_mosi;
  logic       o_spi_cs_n;
  logic       o_busy;
  logic       o_rd_valid;
  logic [7:0] o_rd_data;
  seg7_t      o_hex_lo;
  seg7_t      o_hex_hi;

  integer     seed = 32'hbd02f22a;
  logic [7:0] slave_map [256];   // Sensor register contents
  reg_addr_t  exp_addr;          // Address of the read in flight
  logic [7:0] exp_data;
  int         rd_cnt    = 0;
  int         frame_cnt = 0;
  int         stim_errs = 0;
  int         cmp_errs  = 0;
  int         spi_errs  = 0;

  // SPI slave state
  logic       cs_prev    = 1'b1;
  logic       clk_prev   = 1'b0;
  logic       seen_frame = 1'b0;
  time        t_cs_rise  = 0;
  int         bit_cnt    = 0;
  int         rise_cnt   = 0;
  reg_addr_t  frame_addr = '0;   // Expected address of the open frame
  logic [7:0] rx_byte    = 8'h00;
  logic [7:0] tx_byte    = 8'h00;
  logic [7:0] rx_bytes [$];      // MOSI bytes of the current frame

  spi_reg_reader_top UUT
  (
    .i_Clk      (i_Clk),
    .i_Rst_L    (i_Rst_L),
    .i_start    (i_start),
    .i_reg_addr (i_reg_addr),
    .i_spi_miso (i_spi_miso),
    .o_spi_clk  (o_spi_clk),
    .o_spi_mosi (o_spi_mosi),
    .o_spi_cs_n (o_spi_cs_n),
    .o_busy     (o_busy),
    .o_rd_valid (o_rd_valid),
    .o_rd_data  (o_rd_data),
    .o_hex_lo   (o_hex_lo),
    .o_hex_hi   (o_hex_hi)
  );

  always #(CLK_PERIOD / 2) i_Clk = ~i_Clk;

  // Lit segments as g..a, then inverted for the active-low display
  function automatic seg7_t seg7_ref(input nibble_t nib);
    logic [6:0] lit;
    case (nib)
      4'h0:    lit = 7'h3F;
      4'h1:    lit = 7'h06;
      4'h2:    lit = 7'h5B;
      4'h3:    lit = 7'h4F;
      4'h4:    lit = 7'h66;
      4'h5:    lit = 7'h6D;
      4'h6:    lit = 7'h7D;
      4'h7:    lit = 7'h07;
      4'h8:    lit = 7'h7F;
      4'h9:    lit = 7'h6F;
      4'hA:    lit = 7'h77;
      4'hB:    lit = 7'h7C;  // b
      4'hC:    lit = 7'h39;
      4'hD:    lit = 7'h5E;  // d
      4'hE:    lit = 7'h79;
      default: lit = 7'h71;
    endcase
    return ~lit;
  endfunction

  task automatic show_value(input string name, input logic [7:0] exp_v, input logic [7:0] act_v);
    $display("** Error %s: expected %h, got %h at %0t", name, exp_v, act_v, $time);
  endtask

  ////////////////////////////////////////
  // SPI slave, mode 0
  ////////////////////////////////////////

  always @(posedge o_spi_clk or negedge o_spi_clk or posedge o_spi_cs_n or negedge o_spi_cs_n)
  begin
    if (o_spi_cs_n !== cs_prev)
    begin
      if (o_spi_cs_n === 1'b0)  // Frame opens
      begin
        if (seen_frame && (($time - t_cs_rise) < CS_GAP_MIN))
        begin
          spi_errs++;
          $display("Chip-select was high for only %0t between frames", $time - t_cs_rise);
        end
        frame_cnt++;
        frame_addr = exp_addr;
        bit_cnt  = 0;
        rise_cnt = 0;
        rx_bytes.delete();
        tx_byte    = FILLER;
        i_spi_miso = tx_byte[7];  // MSB ready before first rising edge
      end
      else if (o_spi_cs_n === 1'b1)  // Frame closes
      begin
        t_cs_rise  = $time;
        seen_frame = 1'b1;
        if (rise_cnt != `SPI_FRAME_BYTES * 8)
        begin
          spi_errs++;
          $display("Frame had %0d SPI clock rising edges instead of 24", rise_cnt);
        end
        if (rx_bytes.size() != `SPI_FRAME_BYTES)
        begin
          spi_errs++;
          $display("Frame carried %0d bytes instead of 3", rx_bytes.size());
        end
        else
        begin
          if (rx_bytes[0] != `SNS_CMD_READ)
          begin
            spi_errs++;
            show_value("o_spi_mosi byte 0", `SNS_CMD_READ, rx_bytes[0]);
          end
          if (rx_bytes[1] != frame_addr)
          begin
            spi_errs++;
            show_value("o_spi_mosi byte 1", frame_addr, rx_bytes[1]);
          end
          if (rx_bytes[2] != `SNS_DUMMY_BYTE)
          begin
            spi_errs++;
            show_value("o_spi_mosi byte 2", `SNS_DUMMY_BYTE, rx_bytes[2]);
          end
        end
      end
      cs_prev = o_spi_cs_n;
    end
    else if ((o_spi_cs_n === 1'b0) && (o_spi_clk !== clk_prev))
    begin
      if (o_spi_clk === 1'b1)
      begin
        rise_cnt++;
        rx_byte = {rx_byte[6:0], o_spi_mosi};  // MOSI in on rising edge
        bit_cnt++;
        if (bit_cnt == 8)
        begin
          rx_bytes.push_back(rx_byte);
          bit_cnt = 0;
        end
      end
      else
      begin
        if (bit_cnt == 0)  // Byte boundary, load the next reply
        begin
          tx_byte = (rx_bytes.size() == 2) ? slave_map[rx_bytes[1]] : FILLER;
        end
        else
        begin
          tx_byte = {tx_byte[6:0], 1'b0};
        end
        i_spi_miso = tx_byte[7];
      end
    end
    clk_prev = o_spi_clk;
  end

  ////////////////////////////////////////
  // Result comparison
  ////////////////////////////////////////

  always @(negedge i_Clk)
  begin
    if (i_Rst_L && o_rd_valid)
    begin
      rd_cnt++;
      exp_data = slave_map[exp_addr];
      if (o_rd_data !== exp_data)
      begin
        cmp_errs++;
        show_value("o_rd_data", exp_data, o_rd_data);
      end
      if (o_hex_lo !== seg7_ref(exp_data[3:0]))
      begin
        cmp_errs++;
        show_value("o_hex_lo", 8'(seg7_ref(exp_data[3:0])), 8'(o_hex_lo));
      end
      if (o_hex_hi !== seg7_ref(exp_data[7:4]))
      begin
        cmp_errs++;
        show_value("o_hex_hi", 8'(seg7_ref(exp_data[7:4])), 8'(o_hex_hi));
      end
    end
  end

  // One read, optionally with a second start while busy
  // Entered on a rising edge and left on one
  // With chain_next the next start lands the cycle busy drops, inside the CS gap
  task automatic run_read(input reg_addr_t addr, input logic dup_start,
                          input logic chain_next);
    int start_rd;
    int start_frames;
    int waited;
    start_rd     = rd_cnt;
    start_frames = frame_cnt;
    exp_addr     = addr;
    #2;
    i_reg_addr = addr;
    i_start    = 1'b1;
    @(posedge i_Clk);
    #2;
    i_start = 1'b0;
    if (o_busy !== 1'b1)
    begin
      stim_errs++;
      $display("o_busy did not rise after start for address %h", addr);
    end
    if (dup_start)
    begin
      repeat (10) @(posedge i_Clk);
      #2;
      i_reg_addr = ~addr;  // Must not be latched
      i_start    = 1'b1;
      @(posedge i_Clk);
      #2;
      i_start = 1'b0;
    end
    waited = 0;
    while ((rd_cnt == start_rd) && (waited < READ_TIMEOUT))
    begin
      @(posedge i_Clk);
      waited++;
    end
    if (rd_cnt == start_rd)
    begin
      stim_errs++;
      $display("No o_rd_valid within %0d cycles for address %h", READ_TIMEOUT, addr);
    end
    if (!chain_next)
    begin
      repeat (2) @(posedge i_Clk);
      #2;
      if (o_busy !== 1'b0)
      begin
        stim_errs++;
        $display("o_busy still high after the read of address %h", addr);
      end
      repeat (dup_start ? 120 : 4) @(posedge i_Clk);  // Room for a stray frame to show
    end
    if ((rd_cnt != start_rd + 1) || (frame_cnt != start_frames + 1))
    begin
      stim_errs++;
      $display("Read of %h gave %0d results in %0d frames instead of one", addr,
               rd_cnt - start_rd, frame_cnt - start_frames);
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial
  begin
    logic [31:0] rnd;
    int          total;
    i_Rst_L    = 1'b0;
    i_start    = 1'b0;
    i_reg_addr = '0;
    exp_addr   = '0;
    for (int i = 0; i < 256; i++)
    begin
      rnd = $random(seed);
      slave_map[8'(i)] = rnd[7:0];
    end
    repeat (8) @(posedge i_Clk);
    #2;
    i_Rst_L = 1'b1;
    @(posedge i_Clk);
    #2;
    // Idle outputs after reset
    if (o_spi_cs_n !== 1'b1)
    begin
      stim_errs++;
      show_value("o_spi_cs_n", 8'h01, 8'(o_spi_cs_n));
    end
    if (o_spi_clk !== 1'b0)
    begin
      stim_errs++;
      show_value("o_spi_clk", 8'h00, 8'(o_spi_clk));
    end
    if ((o_busy !== 1'b0) || (o_rd_valid !== 1'b0))
    begin
      stim_errs++;
      $display("o_busy or o_rd_valid high after reset");
    end
    if ((o_hex_lo !== seg7_ref(4'h0)) || (o_hex_hi !== seg7_ref(4'h0)))
    begin
      stim_errs++;
      show_value("o_hex_lo", 8'(seg7_ref(4'h0)), 8'(o_hex_lo));
      show_value("o_hex_hi", 8'(seg7_ref(4'h0)), 8'(o_hex_hi));
    end
    @(posedge i_Clk);
    for (int n = 0; n < NUM_READS; n++)
    begin
      rnd = $random(seed);
      run_read(rnd[7:0], (n % 8) == 3, (n % 4) == 1);
    end
    repeat (20) @(posedge i_Clk);
    total = stim_errs + cmp_errs + spi_errs + UUT.u_checker.fail_cnt;
    $display("Errors: stimulus %0d, readback %0d, SPI frame %0d, assertion %0d",
             stim_errs, cmp_errs, spi_errs, UUT.u_checker.fail_cnt);
    if (total == 0)
    begin
      $display("TEST OK");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog
  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- build.f
+incdir+src
src/spi_bus_pkg.sv
src/sensor_pkg.sv
src/reg_read_decode.sv
src/spi_byte_execute.sv
src/hex_result.sv
src/spi_reg_reader_top.sv
verification/spi_reg_reader_checker.sv
verification/tb_spi_reg_reader.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_spi_reg_reader
FILELIST   := build.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
SIM_ARGS   := +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
